//--- mem_pkg.sv
// Memory request definitions
`default_nettype none

package mem_pkg;

   ////////////////////
   // Client ports

   localparam int MCR_ADDR_W   = 14;               // Microcode RAM word address
   localparam int MCR_DATA_W   = 49;               // Control-store word
   localparam int SDRAM_ADDR_W = 14;               // Reduced main memory address
   localparam int SDRAM_DATA_W = 32;               // Main memory word

   ////////////////////
   // Backing RAM

   // One region bit sits above the 14-bit word address, so the two
   // clients never see each other's words
   localparam int RAM_ADDR_W = 15;
   localparam int RAM_DATA_W = 49;                 // Widest payload

   localparam logic REGION_MCR   = 1'b0;
   localparam logic REGION_SDRAM = 1'b1;

   ////////////////////
   // Word types

   typedef logic [MCR_DATA_W-1:0]   mcr_word_t;
   typedef logic [SDRAM_DATA_W-1:0] sdram_word_t;
   typedef logic [RAM_DATA_W-1:0]   ram_word_t;

endpackage

`default_nettype wire

//--- port_ctrl.sv
// Client port request holder
`timescale 1ns/100ps
`default_nettype none

module port_ctrl #(
   parameter type payload_t = mem_pkg::mcr_word_t,
   parameter int  ADDR_W    = mem_pkg::MCR_ADDR_W
) (
   input  wire                clk50,
   input  wire                reset,
   input  wire                calib_done,

   // Client side
   input  wire                req,          // Strobe, only while ready
   input  wire                write,        // Sampled with req
   input  wire [ADDR_W-1:0]   addr,
   input  wire payload_t      wdata,
   output logic               ready,
   output logic               done,         // One cycle after the ack
   output payload_t           rdata,

   // Arbiter side
   output logic               pending,
   output logic               pend_write,
   output logic [ADDR_W-1:0]  pend_addr,
   output payload_t           pend_wdata,
   input  wire                grant,
   input  wire                ack,
   input  wire payload_t      ack_data
);

   typedef enum logic [1:0] {
      PORT_IDLE,                            // Free for a new request
      PORT_WAIT,                            // Held, no grant yet
      PORT_BUSY                             // Granted, RAM access under way
   } state_t;

   state_t state;

   // Port stays closed until the backing RAM has finished its sweep
   assign ready   = calib_done && (state == PORT_IDLE);
   assign pending = (state != PORT_IDLE);

   ////////////////////
   // Request FSM

   always_ff @(posedge clk50) begin
      if (reset) begin
         state <= PORT_IDLE;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;                      // Pulse only
         case (state)
            PORT_IDLE: begin
               if (req && ready) begin
                  state <= PORT_WAIT;
               end
            end
            PORT_WAIT: begin
               if (grant) begin
                  state <= PORT_BUSY;
               end
            end
            PORT_BUSY: begin
               if (ack) begin
                  state <= PORT_IDLE;       // Ready reopens with done
                  done  <= 1'b1;
               end
            end
            default: begin
               state <= PORT_IDLE;
            end
         endcase
      end
   end

   ////////////////////
   // Held request and result

   always_ff @(posedge clk50) begin
      if (req && ready) begin
         pend_write <= write;
         pend_addr  <= addr;
         pend_wdata <= wdata;
      end
      if (ack) begin
         rdata <= ack_data;                 // Held until the next done
      end
   end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
// Two-port round-robin memory arbiter
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
   input  wire                                clk50,
   input  wire                                reset,

   // Microcode RAM port
   input  wire                                mcr_pending,
   input  wire                                mcr_pend_write,
   input  wire [mem_pkg::MCR_ADDR_W-1:0]      mcr_pend_addr,
   input  wire mem_pkg::mcr_word_t            mcr_pend_wdata,
   output logic                               mcr_grant,
   output logic                               mcr_ack,
   output mem_pkg::mcr_word_t                 mcr_ack_data,

   // Main memory port
   input  wire                                sdram_pending,
   input  wire                                sdram_pend_write,
   input  wire [mem_pkg::SDRAM_ADDR_W-1:0]    sdram_pend_addr,
   input  wire mem_pkg::sdram_word_t          sdram_pend_wdata,
   output logic                               sdram_grant,
   output logic                               sdram_ack,
   output mem_pkg::sdram_word_t               sdram_ack_data,

   // Backing RAM
   output logic                               ram_en,
   output logic                               ram_write,
   output logic [mem_pkg::RAM_ADDR_W-1:0]     ram_addr,
   output mem_pkg::ram_word_t                 ram_wdata,
   input  wire mem_pkg::ram_word_t            ram_rdata
);

   import mem_pkg::*;

   logic mcr_busy;                          // Granted, ack not yet seen
   logic sdram_busy;
   logic last_sdram;                        // Port of the latest grant
   logic mcr_want;
   logic sdram_want;
   logic tag1_sdram;                        // Owner of the access on ram_en
   logic tag2_valid;
   logic tag2_sdram;                        // Owner of the word on ram_rdata

   assign mcr_want   = mcr_pending && !mcr_busy;
   assign sdram_want = sdram_pending && !sdram_busy;

   // On a tie the port that was not granted last goes first
   assign mcr_grant   = mcr_want && (!sdram_want || last_sdram);
   assign sdram_grant = sdram_want && (!mcr_want || !last_sdram);

   ////////////////////
   // Control state

   always_ff @(posedge clk50) begin
      if (reset) begin
         mcr_busy   <= 1'b0;
         sdram_busy <= 1'b0;
         last_sdram <= 1'b0;
         ram_en     <= 1'b0;
         tag2_valid <= 1'b0;
      end else begin
         if (mcr_grant) begin
            mcr_busy <= 1'b1;
         end else if (mcr_ack) begin
            mcr_busy <= 1'b0;
         end
         if (sdram_grant) begin
            sdram_busy <= 1'b1;
         end else if (sdram_ack) begin
            sdram_busy <= 1'b0;
         end
         if (mcr_grant || sdram_grant) begin
            last_sdram <= sdram_grant;
         end
         ram_en     <= mcr_grant || sdram_grant;   // Access one cycle after grant
         tag2_valid <= ram_en;                     // Word back one cycle later
      end
   end

   ////////////////////
   // RAM request and tags

   always_ff @(posedge clk50) begin
      if (sdram_grant) begin
         ram_write <= sdram_pend_write;
         ram_addr  <= {REGION_SDRAM, sdram_pend_addr};
         ram_wdata <= {{(RAM_DATA_W - SDRAM_DATA_W){1'b0}}, sdram_pend_wdata};
      end else begin
         ram_write <= mcr_pend_write;              // Don't care without a grant
         ram_addr  <= {REGION_MCR, mcr_pend_addr};
         ram_wdata <= mcr_pend_wdata;
      end
      tag1_sdram <= sdram_grant;
      tag2_sdram <= tag1_sdram;
   end

   // Second tag stage steers the RAM word back to its port
   assign mcr_ack        = tag2_valid && !tag2_sdram;
   assign sdram_ack      = tag2_valid && tag2_sdram;
   assign mcr_ack_data   = ram_rdata;
   assign sdram_ack_data = ram_rdata[SDRAM_DATA_W-1:0];   // Low word only

endmodule

`default_nettype wire

//--- backing_ram.sv
// On-chip backing RAM with clear sweep
`timescale 1ns/100ps
`default_nettype none

module backing_ram (
   input  wire                             clk50,
   input  wire                             reset,
   input  wire                             en,
   input  wire                             write,
   input  wire [mem_pkg::RAM_ADDR_W-1:0]   addr,
   input  wire mem_pkg::ram_word_t         wdata,
   output mem_pkg::ram_word_t              rdata,
   output logic                            calib_done
);

   import mem_pkg::*;

   ram_word_t                mem [2**RAM_ADDR_W];
   logic [RAM_ADDR_W-1:0]    clear_addr;            // Sweep position
   logic                     wr_en;
   logic [RAM_ADDR_W-1:0]    wr_addr;
   ram_word_t                wr_data;

   ////////////////////
   // Clear sweep

   // After reset every word is written with zero, one per cycle.
   // calib_done rises after the last word and stays up until the
   // next reset, much like a DRAM controller reporting calibration.
   always_ff @(posedge clk50) begin
      if (reset) begin
         clear_addr <= '0;
         calib_done <= 1'b0;
      end else if (!calib_done) begin
         clear_addr <= clear_addr + RAM_ADDR_W'(1);
         if (clear_addr == '1) begin
            calib_done <= 1'b1;                     // Last word cleared
         end
      end
   end

   ////////////////////
   // Memory array

   // Single write port shared by the sweep and client writes
   assign wr_en   = !calib_done || (en && write);
   assign wr_addr = calib_done ? addr : clear_addr;
   assign wr_data = calib_done ? wdata : '0;

   always_ff @(posedge clk50) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Synchronous read, word valid one cycle after en
   always_ff @(posedge clk50) begin
      if (en && calib_done) begin
         rdata <= mem[addr];                        // Old word on a write
      end
   end

endmodule

`default_nettype wire

//--- mem_controller.sv
// Memory request controller top
`timescale 1ns/100ps
`default_nettype none

module mem_controller (
   input  wire                                clk50,
   input  wire                                reset,

   // Microcode RAM port
   input  wire                                mcr_req,
   input  wire                                mcr_write,
   input  wire [mem_pkg::MCR_ADDR_W-1:0]      mcr_addr,
   input  wire mem_pkg::mcr_word_t            mcr_data_in,
   output logic                               mcr_ready,
   output logic                               mcr_done,
   output mem_pkg::mcr_word_t                 mcr_data_out,

   // Main memory port
   input  wire                                sdram_req,
   input  wire                                sdram_write,
   input  wire [mem_pkg::SDRAM_ADDR_W-1:0]    sdram_addr,
   input  wire mem_pkg::sdram_word_t          sdram_data_in,
   output logic                               sdram_ready,
   output logic                               sdram_done,
   output mem_pkg::sdram_word_t               sdram_data_out,

   output logic                               calib_done
);

   import mem_pkg::*;

   ////////////////////
   // Port to arbiter

   logic                     mcr_pending;
   logic                     mcr_pend_write;
   logic [MCR_ADDR_W-1:0]    mcr_pend_addr;
   mcr_word_t                mcr_pend_wdata;
   logic                     mcr_grant;
   logic                     mcr_ack;
   mcr_word_t                mcr_ack_data;

   logic                     sdram_pending;
   logic                     sdram_pend_write;
   logic [SDRAM_ADDR_W-1:0]  sdram_pend_addr;
   sdram_word_t              sdram_pend_wdata;
   logic                     sdram_grant;
   logic                     sdram_ack;
   sdram_word_t              sdram_ack_data;

   ////////////////////
   // Arbiter to RAM

   logic                     ram_en;
   logic                     ram_write;
   logic [RAM_ADDR_W-1:0]    ram_addr;
   ram_word_t                ram_wdata;
   ram_word_t                ram_rdata;

   port_ctrl #(
      .payload_t (mcr_word_t),
      .ADDR_W    (MCR_ADDR_W)
   ) mcr_port_i (
      .clk50      (clk50),
      .reset      (reset),
      .calib_done (calib_done),
      .req        (mcr_req),
      .write      (mcr_write),
      .addr       (mcr_addr),
      .wdata      (mcr_data_in),
      .ready      (mcr_ready),
      .done       (mcr_done),
      .rdata      (mcr_data_out),
      .pending    (mcr_pending),
      .pend_write (mcr_pend_write),
      .pend_addr  (mcr_pend_addr),
      .pend_wdata (mcr_pend_wdata),
      .grant      (mcr_grant),
      .ack        (mcr_ack),
      .ack_data   (mcr_ack_data)
   );

   port_ctrl #(
      .payload_t (sdram_word_t),
      .ADDR_W    (SDRAM_ADDR_W)
   ) sdram_port_i (
      .clk50      (clk50),
      .reset      (reset),
      .calib_done (calib_done),
      .req        (sdram_req),
      .write      (sdram_write),
      .addr       (sdram_addr),
      .wdata      (sdram_data_in),
      .ready      (sdram_ready),
      .done       (sdram_done),
      .rdata      (sdram_data_out),
      .pending    (sdram_pending),
      .pend_write (sdram_pend_write),
      .pend_addr  (sdram_pend_addr),
      .pend_wdata (sdram_pend_wdata),
      .grant      (sdram_grant),
      .ack        (sdram_ack),
      .ack_data   (sdram_ack_data)
   );

   mem_arbiter arb_i (
      .clk50            (clk50),
      .reset            (reset),
      .mcr_pending      (mcr_pending),
      .mcr_pend_write   (mcr_pend_write),
      .mcr_pend_addr    (mcr_pend_addr),
      .mcr_pend_wdata   (mcr_pend_wdata),
      .mcr_grant        (mcr_grant),
      .mcr_ack          (mcr_ack),
      .mcr_ack_data     (mcr_ack_data),
      .sdram_pending    (sdram_pending),
      .sdram_pend_write (sdram_pend_write),
      .sdram_pend_addr  (sdram_pend_addr),
      .sdram_pend_wdata (sdram_pend_wdata),
      .sdram_grant      (sdram_grant),
      .sdram_ack        (sdram_ack),
      .sdram_ack_data   (sdram_ack_data),
      .ram_en           (ram_en),
      .ram_write        (ram_write),
      .ram_addr         (ram_addr),
      .ram_wdata        (ram_wdata),
      .ram_rdata        (ram_rdata)
   );

   backing_ram ram_i (
      .clk50      (clk50),
      .reset      (reset),
      .en         (ram_en),
      .write      (ram_write),
      .addr       (ram_addr),
      .wdata      (ram_wdata),
      .rdata      (ram_rdata),
      .calib_done (calib_done)      // Also opens both ports
   );

endmodule

`default_nettype wire

//--- tb_clock.sv
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
   output logic clk50,
   output logic reset
);

   initial begin
      clk50 = 1'b0;
      forever #20 clk50 = ~clk50;          // 40 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk50);
      #5 reset = 1'b0;                     // Released with the other inputs
   end

endmodule

`default_nettype wire

//--- mem_controller_tb.sv
// Memory controller testbench
`timescale 1ns/100ps
`default_nettype none

module mem_controller_tb;

   import mem_pkg::*;

   localparam int CALIB_TIMEOUT = 40000;
   localparam int DONE_TIMEOUT  = 50;
   localparam int TRAFFIC_OPS   = 400;    // Per port
   localparam int MCR           = 0;
   localparam int SDRAM         = 1;

   logic                     clk50;
   logic                     reset;
   logic                     mcr_req;
   logic                     mcr_write;
   logic [MCR_ADDR_W-1:0]    mcr_addr;
   mcr_word_t                mcr_data_in;
   logic                     mcr_ready;
   logic                     mcr_done;
   mcr_word_t                mcr_data_out;
   logic                     sdram_req;
   logic                     sdram_write;
   logic [SDRAM_ADDR_W-1:0]  sdram_addr;
   sdram_word_t              sdram_data_in;
   logic                     sdram_ready;
   logic                     sdram_done;
   sdram_word_t              sdram_data_out;
   logic                     calib_done;

   int                       errors;
   int                       requests;
   logic                     timed_out;           // A wait ran out of time
   mcr_word_t                mcr_model [int];     // Unwritten words read as zero
   sdram_word_t              sdram_model [int];

   tb_clock clock_i (.clk50(clk50), .reset(reset));

   mem_controller dut_i (.*);

   ////////////////////
   // Helpers

   // Sample point and drive point, 5 ns after the rising edge
   task automatic step();
      @(posedge clk50);
      #5;
   endtask

   function automatic string port_name(int port);
      return (port == MCR) ? "mcr" : "sdram";
   endfunction

   function automatic logic port_ready(int port);
      return (port == MCR) ? mcr_ready : sdram_ready;
   endfunction

   function automatic logic port_done(int port);
      return (port == MCR) ? mcr_done : sdram_done;
   endfunction

   function automatic ram_word_t port_rdata(int port);
      return (port == MCR) ? mcr_data_out : ram_word_t'(sdram_data_out);
   endfunction

   function automatic ram_word_t model_read(int port, int addr);
      if (port == MCR)
         return mcr_model.exists(addr) ? mcr_model[addr] : ram_word_t'(0);
      return sdram_model.exists(addr) ? ram_word_t'(sdram_model[addr]) : ram_word_t'(0);
   endfunction

   function automatic ram_word_t rand_word();
      return ram_word_t'({$urandom(), $urandom()});
   endfunction

   task automatic report_mismatch(string name, ram_word_t expected, ram_word_t actual);
      errors++;
      $display("Fail %0t %s expected %h actual %h", $time, name, expected, actual);
   endtask

   task automatic report_error(string msg);
      errors++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic finish_run();
      $display("Requests %0d, errors %0d", requests, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   endtask

   task automatic drive_port(int port, logic req, logic write, int addr, ram_word_t data);
      if (port == MCR) begin
         mcr_req     = req;
         mcr_write   = write;
         mcr_addr    = addr[MCR_ADDR_W-1:0];
         mcr_data_in = data;
      end else begin
         sdram_req     = req;
         sdram_write   = write;
         sdram_addr    = addr[SDRAM_ADDR_W-1:0];
         sdram_data_in = data[SDRAM_DATA_W-1:0];   // Main memory keeps 32 bits
      end
   endtask

   ////////////////////
   // Requests

   // One request from ready to done, read word checked against the model
   task automatic access(int port, logic write, int addr, ram_word_t data);
      ram_word_t expected;
      int        waited;
      if (!timed_out) begin
         waited = 0;
         while (!port_ready(port) && waited < DONE_TIMEOUT) begin
            step();
            waited++;
         end
         if (!port_ready(port)) begin
            report_error({port_name(port), " port never became ready"});
            timed_out = 1'b1;
         end else begin
            expected = model_read(port, addr);
            if (write && port == MCR)
               mcr_model[addr] = data;
            if (write && port == SDRAM)
               sdram_model[addr] = data[SDRAM_DATA_W-1:0];
            drive_port(port, 1'b1, write, addr, data);
            step();
            drive_port(port, 1'b0, 1'b0, addr, data);
            waited = 1;
            while (!port_done(port) && waited < DONE_TIMEOUT) begin
               if (port_ready(port))
                  report_mismatch({port_name(port), "_ready"}, 0, 1);  // Closed while held
               step();
               waited++;
            end
            if (!port_done(port)) begin
               report_error({port_name(port), " request got no done within 50 cycles"});
               timed_out = 1'b1;
            end else begin
               requests++;
               if (waited < 4)
                  report_error({port_name(port), "_done came sooner than 4 cycles after req"});
               if (!port_ready(port))
                  report_mismatch({port_name(port), "_ready"}, 1, 0);     // Reopens with done
               if (!write && port_rdata(port) !== expected)
                  report_mismatch({port_name(port), "_data_out"}, expected, port_rdata(port));
            end
         end
      end
   endtask

   task automatic idle(int port, int cycles);
      repeat (cycles) begin
         step();
         if (port_done(port))
            report_error({port_name(port), "_done pulsed with no request"});
      end
   endtask

   task automatic random_traffic(int port);
      repeat (TRAFFIC_OPS) begin
         if (!timed_out) begin
            idle(port, $urandom_range(3));
            access(port, $urandom_range(1), $urandom_range(15), rand_word());
         end
      end
   endtask

   ////////////////////
   // Test sequence

   initial begin
      int        addr;
      int        cycles;
      ram_word_t word;
      errors    = 0;
      requests  = 0;
      timed_out = 1'b0;
      void'($urandom(32'h78f2));
      drive_port(MCR, 1'b0, 1'b0, 0, '0);
      drive_port(SDRAM, 1'b0, 1'b0, 0, '0);

      // Reset and clear sweep keep both ports closed
      step();
      cycles = 0;
      while (!calib_done && cycles < CALIB_TIMEOUT) begin
         if (mcr_ready)
            report_mismatch("mcr_ready", 0, 1);
         if (sdram_ready)
            report_mismatch("sdram_ready", 0, 1);
         if (mcr_done)
            report_mismatch("mcr_done", 0, 1);
         if (sdram_done)
            report_mismatch("sdram_done", 0, 1);
         step();
         cycles++;
      end
      if (!calib_done) begin
         report_error("calib_done did not rise within 40000 cycles");
         timed_out = 1'b1;
      end else begin
         // One cleared word per cycle over the whole array
         if (cycles < 2**RAM_ADDR_W)
            report_error("calib_done rose before the clear sweep covered every word");
         if (!mcr_ready)
            report_mismatch("mcr_ready", 1, 0);
         if (!sdram_ready)
            report_mismatch("sdram_ready", 1, 0);
      end

      // Write then read back on each port
      addr = 'h1000 + $urandom_range(255);
      access(MCR, 1'b1, addr, rand_word());
      access(MCR, 1'b0, addr, '0);
      addr = 'h1000 + $urandom_range(255);
      access(SDRAM, 1'b1, addr, rand_word());
      access(SDRAM, 1'b0, addr, '0);

      // Same address on both ports, each region keeps its own word
      addr = 'h1100 + $urandom_range(255);
      word = rand_word();
      fork
         access(MCR, 1'b1, addr, word);
         access(SDRAM, 1'b1, addr, ~word);
      join
      fork
         access(MCR, 1'b0, addr, '0);
         access(SDRAM, 1'b0, addr, '0);
      join

      fork
         random_traffic(MCR);
         random_traffic(SDRAM);
      join

      // Never written, still zero from the clear sweep
      repeat (8) begin
         addr = 'h3000 + $urandom_range('hfff);
         access(MCR, 1'b0, addr, '0);
         access(SDRAM, 1'b0, addr, '0);
      end

      finish_run();
   end

endmodule

`default_nettype wire

//--- vlog.f
mem_pkg.sv
port_ctrl.sv
mem_arbiter.sv
backing_ram.sv
mem_controller.sv
tb_clock.sv
mem_controller_tb.sv

//--- Bender.yml
package:
  name: mem_controller

sources:
  - mem_pkg.sv
  - port_ctrl.sv
  - mem_arbiter.sv
  - backing_ram.sv
  - mem_controller.sv
  - target: test
    files:
      - tb_clock.sv
      - mem_controller_tb.sv
